//--- load_store_unit.sv
// load/store unit top level
`timescale 1ns/1ps
`include "lsu_consts.svh"

module load_store_unit (
  input  logic              clk_i,
  input  logic              rst_ni,

  // core side
  input  logic              lsu_req_i,
  input  lsu_pkg::lsu_req_t req_i,        // held until lsu_req_done_o
  output logic              addr_incr_req_o,
  output lsu_pkg::addr_t    addr_last_o,
  output logic              lsu_req_done_o,
  output logic              lsu_resp_valid_o,
  output logic              lsu_rdata_valid_o,
  output lsu_pkg::word_t    lsu_rdata_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o,

  // data bus
  output logic              data_req_o,
  output lsu_pkg::addr_t    data_addr_o,  // word aligned
  output logic              data_we_o,
  output lsu_pkg::be_t      data_be_o,
  output lsu_pkg::word_t    data_wdata_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_err_i,
  input  logic              data_pmp_err_i,
  input  lsu_pkg::word_t    data_rdata_i
);

  logic second_part;  // second word of a split access
  logic ctrl_update;  // latch control for the response
  logic rdata_update; // latch first word of a split load

  assign data_addr_o = {req_i.addr[`LSU_ADDR_W-1:2], 2'b00};
  assign data_we_o   = req_i.we;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .req_i             (req_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_pmp_err_i    (data_pmp_err_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .addr_last_o       (addr_last_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  lsu_store_align u_store_align (
    .req_i         (req_i),
    .second_part_i (second_part),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

//--- lsu.f
+incdir+.
lsu_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_ctrl_fsm.sv
load_store_unit.sv
tb_clk_gen.sv
tb_data_mem.sv
tb_load_store_unit.sv

//--- lsu_consts.svh
// load/store unit constants
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths, fixed by the data bus
//////////////////////////////////////////////////////////////////////

`define LSU_ADDR_W 32 // byte address
`define LSU_DATA_W 32 // data word, no tag bit
`define LSU_BE_W   4  // one enable per byte lane

//////////////////////////////////////////////////////////////////////
// access data type codes
//////////////////////////////////////////////////////////////////////

`define LSU_TYPE_WORD 2'b00
`define LSU_TYPE_HALF 2'b01
// byte access, 2'b11 decodes the same way
`define LSU_TYPE_BYTE 2'b10

`endif

//--- lsu_ctrl_fsm.sv
// load/store access control
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_ctrl_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lsu_req_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_err_i,
  input  logic              data_pmp_err_i,  // address phase, blocks the grant
  output logic              data_req_o,
  output logic              addr_incr_req_o, // core moves to the next word
  output logic              second_part_o,
  output logic              ctrl_update_o,
  output logic              rdata_update_o,
  output lsu_pkg::addr_t    addr_last_o,     // trap value and address base
  output logic              lsu_req_done_o,
  output logic              lsu_resp_valid_o,
  output logic              lsu_rdata_valid_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o
);

  import lsu_pkg::*;

  ls_fsm_e ls_fsm_cs, ls_fsm_ns;
  offset_t offset;
  addr_t   addr_last_q, addr_last_d;
  logic    split_access;            // needs two bus words
  logic    handle_mis_q, handle_mis_d; // second half in progress
  logic    pmp_err_q, pmp_err_d;
  logic    lsu_err_q, lsu_err_d;    // error of the first half
  logic    we_q;
  logic    addr_update, lsu_go, resp_valid, any_err;

  assign offset       = req_i.addr[1:0];
  assign split_access = ((req_i.dtype == `LSU_TYPE_WORD) && (offset != 2'b00)) ||
                        ((req_i.dtype == `LSU_TYPE_HALF) && (offset == 2'b11));

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns       = ls_fsm_cs;
    handle_mis_d    = handle_mis_q;
    pmp_err_d       = pmp_err_q;
    lsu_err_d       = lsu_err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    addr_update     = 1'b0;
    lsu_go          = 1'b0;
    unique case (ls_fsm_cs)
      IDLE: begin
        pmp_err_d = 1'b0;
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_go     = 1'b1;
          pmp_err_d  = data_pmp_err_i; // held for the wait states
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            handle_mis_d  = split_access;
            ls_fsm_ns     = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i || pmp_err_q) begin // a pmp error never sees a grant
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          handle_mis_d  = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end
      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1; // second word goes out now
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i || pmp_err_q) begin
          pmp_err_d      = data_pmp_err_i;         // now for the second half
          lsu_err_d      = data_err_i | pmp_err_q; // first half result
          rdata_update_o = ~we_q;
          addr_update    = data_gnt_i & ~(data_err_i | pmp_err_q);
          handle_mis_d   = ~data_gnt_i;
          ls_fsm_ns      = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          ls_fsm_ns    = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end
      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = handle_mis_q; // only for a pending second half
        if (data_gnt_i || pmp_err_q) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q;   // keep the first failing address
          handle_mis_d  = 1'b0;
          ls_fsm_ns     = IDLE;
        end
      end
      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1; // keeps the second address for addr_last
        if (data_rvalid_i) begin
          pmp_err_d      = data_pmp_err_i;
          lsu_err_d      = data_err_i;    // granted, so no pmp error here
          addr_update    = ~data_err_i;
          rdata_update_o = ~we_q;
          ls_fsm_ns      = IDLE;
        end
      end
      default: ls_fsm_ns = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and status registers
  //////////////////////////////////////////////////////////////////////

  // unaligned address for the first half, word aligned for the second
  assign addr_last_d = addr_incr_req_o ? {req_i.addr[`LSU_ADDR_W-1:2], 2'b00} : req_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= IDLE;
      handle_mis_q <= 1'b0;
      pmp_err_q    <= 1'b0;
      lsu_err_q    <= 1'b0;
      we_q         <= 1'b0;
      addr_last_q  <= '0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      pmp_err_q    <= pmp_err_d;
      lsu_err_q    <= lsu_err_d;
      if (ctrl_update_o) we_q <= req_i.we;
      if (addr_update) addr_last_q <= addr_last_d;
    end
  end

  // response outputs
  assign any_err           = lsu_err_q | data_err_i | pmp_err_q; // either half
  assign resp_valid        = (data_rvalid_i | pmp_err_q) & (ls_fsm_cs == IDLE);
  assign lsu_req_done_o    = (lsu_go | (ls_fsm_cs != IDLE)) & (ls_fsm_ns == IDLE);
  assign lsu_resp_valid_o  = resp_valid;
  assign lsu_rdata_valid_o = (ls_fsm_cs == IDLE) & data_rvalid_i & ~any_err & ~we_q;
  assign load_err_o        = resp_valid & any_err & ~we_q;
  assign store_err_o       = resp_valid & any_err & we_q;
  assign second_part_o     = handle_mis_q;
  assign addr_last_o       = addr_last_q;
  assign busy_o            = (ls_fsm_cs != IDLE);

endmodule

//--- lsu_load_align.sv
// load data realignment and extension
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_load_align (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              ctrl_update_i,  // capture request control
  input  logic              rdata_update_i, // capture first bus word
  input  lsu_pkg::word_t    data_rdata_i,
  output lsu_pkg::word_t    lsu_rdata_o
);

  import lsu_pkg::*;

  xfer_ctrl_t                ctrl_q;
  logic [`LSU_DATA_W-1:8]    rdata_q;   // upper bytes of the first word
  word_t                     rdata_w;   // realigned word
  logic [15:0]               rdata_h;   // selected half
  logic [7:0]                rdata_b;   // selected byte
  logic                      sign_h, sign_b;

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ctrl_q.offset   <= req_i.addr[1:0];
      ctrl_q.dtype    <= req_i.dtype;
      ctrl_q.sign_ext <= req_i.sign_ext;
    end
  end

  // byte 0 of the first word is never part of a split result
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // first word bytes sit low and the current word fills the top
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // only a half word at offset 3 crosses into the second word
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // a byte always sits within the current word
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   rdata_b = data_rdata_i[7:0];
      2'b01:   rdata_b = data_rdata_i[15:8];
      2'b10:   rdata_b = data_rdata_i[23:16];
      default: rdata_b = data_rdata_i[31:24];
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // extension and size select
  //////////////////////////////////////////////////////////////////////

  assign sign_h = ctrl_q.sign_ext & rdata_h[15]; // zero fill unless signed
  assign sign_b = ctrl_q.sign_ext & rdata_b[7];

  always_comb begin
    unique case (ctrl_q.dtype)
      `LSU_TYPE_WORD: lsu_rdata_o = rdata_w;
      `LSU_TYPE_HALF: lsu_rdata_o = {{16{sign_h}}, rdata_h};
      default:        lsu_rdata_o = {{24{sign_b}}, rdata_b}; // both byte codes
    endcase
  end

endmodule

//--- lsu_pkg.sv
// load/store unit types
`include "lsu_consts.svh"

package lsu_pkg;

  // vectors with a meaning of their own
  typedef logic [`LSU_ADDR_W-1:0] addr_t;   // byte address
  typedef logic [`LSU_DATA_W-1:0] word_t;   // bus data word
  typedef logic [`LSU_BE_W-1:0]   be_t;     // byte lane enables
  typedef logic [1:0]             offset_t; // byte within a word
  typedef logic [1:0]             dtype_t;  // word, half or byte

  // request fields from the core, held until request done
  typedef struct packed {
    logic    we;       // store when set
    dtype_t  dtype;    // access size
    logic    sign_ext; // sign extend loaded halves and bytes
    addr_t   addr;     // byte address from the address generator
    word_t   wdata;    // store data, lsb aligned
  } lsu_req_t;

  // transaction control kept for the response phase
  typedef struct packed {
    offset_t offset;   // low address bits of the first half
    dtype_t  dtype;
    logic    sign_ext;
  } xfer_ctrl_t;

  // access sequencing
  typedef enum logic [2:0] {
    IDLE,                     // ready, also takes the final rvalid
    WAIT_GNT_MIS,             // first half of a split access not granted yet
    WAIT_RVALID_MIS,          // first half granted, second half requested
    WAIT_GNT,                 // waiting for the last grant
    WAIT_RVALID_MIS_GNTS_DONE // both granted, first rvalid still due
  } ls_fsm_e;

endpackage

//--- lsu_store_align.sv
// store byte enables and write data
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_store_align (
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              second_part_i, // second bus word of a split access
  output lsu_pkg::be_t      data_be_o,
  output lsu_pkg::word_t    data_wdata_o
);

  import lsu_pkg::*;

  offset_t offset;

  assign offset = req_i.addr[1:0];

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.dtype)
      `LSU_TYPE_WORD: begin
        if (!second_part_i) begin
          // first word, lanes from the offset upward
          unique case (offset)
            2'b00:   data_be_o = 4'b1111;
            2'b01:   data_be_o = 4'b1110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000;
          endcase
        end else begin
          // second word, the remaining low lanes
          unique case (offset)
            2'b00:   data_be_o = 4'b0000; // aligned words never split
            2'b01:   data_be_o = 4'b0001;
            2'b10:   data_be_o = 4'b0011;
            default: data_be_o = 4'b0111;
          endcase
        end
      end

      `LSU_TYPE_HALF: begin
        if (!second_part_i) begin
          unique case (offset)
            2'b00:   data_be_o = 4'b0011;
            2'b01:   data_be_o = 4'b0110;
            2'b10:   data_be_o = 4'b1100;
            default: data_be_o = 4'b1000; // upper byte goes in the next word
          endcase
        end else begin
          data_be_o = 4'b0001; // only offset 3 splits
        end
      end

      default: begin // byte, both codes
        unique case (offset)
          2'b00:   data_be_o = 4'b0001;
          2'b01:   data_be_o = 4'b0010;
          2'b10:   data_be_o = 4'b0100;
          default: data_be_o = 4'b1000;
        endcase
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////////////////////////

  // rotate left by the offset, bytes that wrap land in the low lanes
  // and are picked up by the second half's enables
  always_comb begin
    unique case (offset)
      2'b00:   data_wdata_o = req_i.wdata;
      2'b01:   data_wdata_o = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   data_wdata_o = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: data_wdata_o = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f lsu.f --top-module tb_load_store_unit -o sim_lsu
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam time HALF_PERIOD = 10ns; // 20 ns clock

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;                    // reset from time zero
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // hold reset for 4 rising edges, release away from the edge
  initial begin
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_data_mem.sv
// data bus memory model
`timescale 1ns/1ps

module tb_data_mem (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic        err_o,
  output logic        pmp_err_o,
  output logic [31:0] rdata_o
);

  localparam logic [31:0] PMP_ADDR = 32'h0000_0400; // word 0x100
  localparam logic [31:0] ERR_ADDR = 32'h0000_0410; // word 0x104
  localparam logic [31:0] FILL_KEY = 32'hA5C3_0F96;

  logic [31:0] mem [0:511];  // bytes 0x000 to 0x7ff
  logic [31:0] lcg_q;        // grant delay source
  logic [1:0]  wait_q;       // cycles until the next grant
  logic [8:0]  idx;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // every word holds its own byte address xor the key
  initial begin
    for (int i = 0; i < 512; i++) begin
      mem[i] = (32'(i) << 2) ^ FILL_KEY;
    end
  end

  assign idx       = addr_i[10:2];
  assign pmp_err_o = req_i && (addr_i == PMP_ADDR);        // address phase only
  assign gnt_o     = req_i && !pmp_err_o && (wait_q == 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcg_q    <= 32'h887e;
      wait_q   <= 2'd0;
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= gnt_o;                                     // response one cycle on
      if (gnt_o) begin
        err_o   <= (addr_i == ERR_ADDR);
        rdata_o <= mem[idx];
        lcg_q   <= lcg_next(lcg_q);
        wait_q  <= (lcg_q[17:16] == 2'd3) ? 2'd0 : lcg_q[17:16]; // 0 to 2
        if (we_i && (addr_i != ERR_ADDR)) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else if (req_i && (wait_q != 2'd0)) begin
        wait_q <= wait_q - 2'd1;                             // count down the stall
      end
    end
  end

endmodule

//--- tb_load_store_unit.sv
// load/store unit testbench
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_load_store_unit;

  import lsu_pkg::*;

  // one table row with the access and what must come back
  typedef struct packed {
    logic   we;
    dtype_t dtype;
    logic   sext;
    addr_t  addr;
    word_t  wdata;
    word_t  rdata;
    logic   err;
    addr_t  last;
  } vec_t;

  logic     clk, rst_n;
  logic     lsu_req;
  lsu_req_t req;
  logic     addr_incr_req_o, lsu_req_done_o, lsu_resp_valid_o, lsu_rdata_valid_o;
  logic     load_err_o, store_err_o, busy_o;
  addr_t    addr_last_o, data_addr_o;
  word_t    lsu_rdata_o, data_wdata_o, data_rdata_i;
  logic     data_req_o, data_we_o, data_gnt_i, data_rvalid_i, data_err_i, data_pmp_err_i;
  be_t      data_be_o;
  vec_t     vecs[$];
  logic     table_ready;
  int       err_cnt, fail_tests;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  load_store_unit dut0 (
    .clk_i(clk), .rst_ni(rst_n), .lsu_req_i(lsu_req), .req_i(req),
    .addr_incr_req_o(addr_incr_req_o), .addr_last_o(addr_last_o),
    .lsu_req_done_o(lsu_req_done_o), .lsu_resp_valid_o(lsu_resp_valid_o),
    .lsu_rdata_valid_o(lsu_rdata_valid_o), .lsu_rdata_o(lsu_rdata_o),
    .load_err_o(load_err_o), .store_err_o(store_err_o), .busy_o(busy_o),
    .data_req_o(data_req_o), .data_addr_o(data_addr_o), .data_we_o(data_we_o),
    .data_be_o(data_be_o), .data_wdata_o(data_wdata_o), .data_gnt_i(data_gnt_i),
    .data_rvalid_i(data_rvalid_i), .data_err_i(data_err_i),
    .data_pmp_err_i(data_pmp_err_i), .data_rdata_i(data_rdata_i)
  );

  tb_data_mem u_mem (
    .clk_i(clk), .rst_ni(rst_n), .req_i(data_req_o), .addr_i(data_addr_o),
    .we_i(data_we_o), .be_i(data_be_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt_i),
    .rvalid_o(data_rvalid_i), .err_o(data_err_i), .pmp_err_o(data_pmp_err_i),
    .rdata_o(data_rdata_i)
  );

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  task automatic add_vec(input logic we, input dtype_t dt, input logic sx, input addr_t a,
                         input word_t wd, input word_t rd, input logic er, input addr_t la);
    vec_t v;
    v.we    = we;
    v.dtype = dt;
    v.sext  = sx;
    v.addr  = a;
    v.wdata = wd;
    v.rdata = rd;
    v.err   = er;
    v.last  = la;
    vecs.push_back(v);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // one access from request to response, as the core would run it
  task automatic run_vec(input int n, input vec_t v);
    logic done, resp, split, seen_incr, seen_busy;
    int   errs_before;
    errs_before = err_cnt;
    split = ((v.dtype == `LSU_TYPE_WORD) && (v.addr[1:0] != 2'b00)) ||
            ((v.dtype == `LSU_TYPE_HALF) && (v.addr[1:0] == 2'b11));
    done      = 1'b0;
    resp      = 1'b0;
    seen_incr = 1'b0;
    seen_busy = 1'b0;
    @(negedge clk);
    lsu_req      = 1'b1;
    req.we       = v.we;
    req.dtype    = v.dtype;
    req.sign_ext = v.sext;
    req.addr     = v.addr;
    req.wdata    = v.wdata;
    while (!done) begin
      // addr_incr_req_o comes from state, stable since the rising edge
      if (addr_incr_req_o) begin           // address generator steps a word
        seen_incr = 1'b1;
        req.addr  = addr_last_o + 32'd4;
      end
      #7;
      if (busy_o) seen_busy = 1'b1;
      done = lsu_req_done_o;
      @(negedge clk);
    end
    lsu_req = 1'b0;
    while (!resp) begin
      #5;
      resp = lsu_resp_valid_o;
      if (!resp) @(negedge clk);
    end
    check_bit("load_err_o", load_err_o, v.err & ~v.we);
    check_bit("store_err_o", store_err_o, v.err & v.we);
    check_bit("lsu_rdata_valid_o", lsu_rdata_valid_o, ~v.err & ~v.we);
    if (!v.we && !v.err) check_word("lsu_rdata_o", lsu_rdata_o, v.rdata);
    check_word("addr_last_o", addr_last_o, v.last);
    check_bit("addr_incr_req_o seen", seen_incr, split);
    if (split) check_bit("busy_o during split", seen_busy, 1'b1);
    check_bit("busy_o", busy_o, 1'b0);             // idle again
    check_bit("data_req_o", data_req_o, 1'b0);
    if (err_cnt != errs_before) fail_tests++;
    $display("test %0d %s addr %h: %s", n, v.we ? "store" : "load", v.addr,
             (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////
  // table and main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    lsu_req     = 1'b0;
    req         = '0;
    table_ready = 1'b0;
    err_cnt     = 0;
    fail_tests  = 0;
    // we, type, sext, addr, wdata, rdata, err, addr_last
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h20, 32'h0, 32'hA5C30FB6, 0, 32'h20);
    add_vec(0, `LSU_TYPE_HALF, 0, 32'h20, 32'h0, 32'h00000FB6, 0, 32'h20);
    add_vec(0, `LSU_TYPE_HALF, 0, 32'h21, 32'h0, 32'h0000C30F, 0, 32'h21);
    add_vec(0, `LSU_TYPE_HALF, 1, 32'h22, 32'h0, 32'hFFFFA5C3, 0, 32'h22);
    add_vec(0, `LSU_TYPE_BYTE, 1, 32'h24, 32'h0, 32'hFFFFFFB2, 0, 32'h24);
    add_vec(0, `LSU_TYPE_BYTE, 0, 32'h25, 32'h0, 32'h0000000F, 0, 32'h25);
    add_vec(0, `LSU_TYPE_BYTE, 1, 32'h26, 32'h0, 32'hFFFFFFC3, 0, 32'h26);
    add_vec(0, `LSU_TYPE_BYTE, 0, 32'h27, 32'h0, 32'h000000A5, 0, 32'h27);
    // misaligned loads across 0x28 and 0x2c
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h29, 32'h0, 32'hBAA5C30F, 0, 32'h2C);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h2A, 32'h0, 32'h0FBAA5C3, 0, 32'h2C);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h2B, 32'h0, 32'hC30FBAA5, 0, 32'h2C);
    add_vec(0, `LSU_TYPE_HALF, 1, 32'h2B, 32'h0, 32'hFFFFBAA5, 0, 32'h2C);
    // stores with a read back after each
    add_vec(1, `LSU_TYPE_WORD, 0, 32'h30, 32'h11223344, 32'h0, 0, 32'h30);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h30, 32'h0, 32'h11223344, 0, 32'h30);
    add_vec(1, `LSU_TYPE_HALF, 0, 32'h36, 32'h00005566, 32'h0, 0, 32'h36);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h34, 32'h0, 32'h55660FA2, 0, 32'h34);
    add_vec(1, `LSU_TYPE_BYTE, 0, 32'h39, 32'h00000077, 32'h0, 0, 32'h39);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h38, 32'h0, 32'hA5C377AE, 0, 32'h38);
    add_vec(1, `LSU_TYPE_WORD, 0, 32'h3E, 32'h8899AABB, 32'h0, 0, 32'h40);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h3C, 32'h0, 32'hAABB0FAA, 0, 32'h3C);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h40, 32'h0, 32'hA5C38899, 0, 32'h40);
    add_vec(1, `LSU_TYPE_HALF, 0, 32'h47, 32'h0000CCDD, 32'h0, 0, 32'h48);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h44, 32'h0, 32'hDDC30FD2, 0, 32'h44);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h48, 32'h0, 32'hA5C30FCC, 0, 32'h48);
    // pmp word and a split load whose second word errors
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h400, 32'h0, 32'h0, 1, 32'h400);
    add_vec(1, `LSU_TYPE_WORD, 0, 32'h400, 32'h12345678, 32'h0, 1, 32'h400);
    add_vec(0, `LSU_TYPE_WORD, 0, 32'h40E, 32'h0, 32'h0, 1, 32'h410);
    table_ready = 1'b1;

    @(posedge rst_n);
    #5;
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("data_req_o", data_req_o, 1'b0);
    check_bit("addr_incr_req_o", addr_incr_req_o, 1'b0);
    check_bit("lsu_req_done_o", lsu_req_done_o, 1'b0);
    check_bit("lsu_resp_valid_o", lsu_resp_valid_o, 1'b0);
    check_bit("lsu_rdata_valid_o", lsu_rdata_valid_o, 1'b0);
    check_bit("load_err_o", load_err_o, 1'b0);
    check_bit("store_err_o", store_err_o, 1'b0);
    if (err_cnt != 0) fail_tests++;
    $display("reset check: %s", (err_cnt == 0) ? "ok" : "failed");

    foreach (vecs[i]) run_vec(i, vecs[i]);

    $display("%0d tests run, %0d failed, %0d check errors", vecs.size() + 1, fail_tests,
             err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // 20 cycles per table entry plus reset
  initial begin
    wait (table_ready);
    repeat ((vecs.size() + 1) * 20) @(posedge clk);
    $display("timeout: an access did not finish within its cycle budget");
    $display("TEST FAILED");
    $finish;
  end

endmodule
